// File: conv_accum_pkg.sv
`default_nettype none

package conv_accum_pkg;

  ////////////////////
  // Widths

  // Per-channel result from the convolution engine
  localparam int PXL_W = 16;

  // Running partial sum, lane sum and layer bias
  localparam int PSUM_W = 32;

  // Activated pixel after ReLU and saturation
  localparam int OUT_W = 16;

  ////////////////////
  // Vector types

  // Signed input pixel of one channel
  typedef logic signed [PXL_W-1:0] pxl_t;

  // Signed accumulator word
  typedef logic signed [PSUM_W-1:0] psum_t;

  // Unsigned output, ReLU leaves nothing negative
  typedef logic [OUT_W-1:0] out_t;

  // Saturation ceiling
  localparam out_t OUT_MAX = '1;

endpackage

`default_nettype wire

// File: psum_if.sv
`timescale 1ns/1ns
`default_nettype none

interface psum_if
  import conv_accum_pkg::*;
#(
  parameter int IMAGE_SIZE = 16
) ();

  localparam int ADDR_W = $clog2(IMAGE_SIZE);

  psum_t             sum;
  logic              valid;
  logic [ADDR_W-1:0] index;
  logic              last;

  // Lane drives, no handshake back
  modport lane (output sum, valid, index, last);

  // Combiner samples in the valid cycle
  modport comb (input sum, valid, index, last);

endinterface

`default_nettype wire

// File: psum_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module psum_buffer
  import conv_accum_pkg::*;
#(
  parameter int IMAGE_SIZE = 16,
  localparam int ADDR_W = $clog2(IMAGE_SIZE)
) (
  input  logic              clk,
  input  logic [ADDR_W-1:0] rd_addr,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  psum_t             wr_data,
  output psum_t             rd_data
);

  // One word per pixel position of the image
  psum_t mem [IMAGE_SIZE];

  ////////////////////
  // Write port

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////
  // Registered read, address taken every cycle

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: channel_in_accum.sv
`timescale 1ns/1ns
`default_nettype none

module channel_in_accum
  import conv_accum_pkg::*;
#(
  parameter int IMAGE_SIZE     = 16,
  parameter int CHANNEL_NUM_IN = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic valid_in,
  input  pxl_t pxl_in,
  psum_if.lane out
);

  localparam int ADDR_W = $clog2(IMAGE_SIZE);
  localparam int CH_W   = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [CH_W-1:0]   chan_t;

  localparam addr_t LAST_PIX = addr_t'(IMAGE_SIZE - 1);
  localparam chan_t LAST_CH  = chan_t'(CHANNEL_NUM_IN - 1);

  // Position counters
  addr_t pix_cnt;
  chan_t ch_cnt;
  logic  pix_wrap;

  // Stage 1, travels alongside the buffer read
  logic  s1_valid;
  pxl_t  s1_pxl;
  addr_t s1_addr;
  logic  s1_first;
  logic  s1_last_ch;
  logic  s1_last_pix;

  // Stage 2 arithmetic
  psum_t rd_sum;
  psum_t base;
  psum_t acc;

  ////////////////////
  // Pixel and channel counters

  assign pix_wrap = (pix_cnt == LAST_PIX);

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_cnt <= '0;
      ch_cnt  <= '0;
    end else if (valid_in) begin
      if (pix_wrap) begin
        pix_cnt <= '0;
        // Next channel starts with the next image
        if (ch_cnt == LAST_CH) begin
          ch_cnt <= '0;
        end else begin
          ch_cnt <= ch_cnt + 1'b1;
        end
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // Stage 1

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_in) begin
      s1_pxl      <= pxl_in;
      s1_addr     <= pix_cnt;
      s1_first    <= (ch_cnt == '0);
      s1_last_ch  <= (ch_cnt == LAST_CH);
      s1_last_pix <= pix_wrap;
    end
  end

  // Read is issued with the sampled pixel, write lands one edge later.
  // The same address comes back only IMAGE_SIZE inputs later
  psum_buffer #(
    .IMAGE_SIZE (IMAGE_SIZE)
  ) buffer_i (
    .clk     (clk),
    .rd_addr (pix_cnt),
    .wr_en   (s1_valid),
    .wr_addr (s1_addr),
    .wr_data (acc),
    .rd_data (rd_sum)
  );

  ////////////////////
  // Stage 2, add and write back

  // First channel starts from zero, stale words are ignored
  assign base = s1_first ? '0 : rd_sum;
  assign acc  = base + psum_t'(s1_pxl);

  always_ff @(posedge clk) begin
    if (reset) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= s1_valid && s1_last_ch;
    end
  end

  // Finished sum of this lane
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      out.sum   <= acc;
      out.index <= s1_addr;
      out.last  <= s1_last_pix;
    end
  end

endmodule

`default_nettype wire

// File: bias_relu_combiner.sv
`timescale 1ns/1ns
`default_nettype none

module bias_relu_combiner
  import conv_accum_pkg::*;
#(
  parameter int IMAGE_SIZE = 16
) (
  input  logic                          clk,
  input  logic                          reset,
  psum_if.comb                          lane_a,
  psum_if.comb                          lane_b,
  input  psum_t                         bias,
  output out_t                          pxl_out,
  output logic                          valid_out,
  output logic [$clog2(IMAGE_SIZE)-1:0] out_index,
  output logic                          frame_done
);

  // Two guard bits for the sum of three PSUM_W terms
  typedef logic signed [PSUM_W+1:0] wide_t;

  logic  take;
  wide_t total;
  out_t  act;

  // Both lanes run on one strobe, so the valids line up
  assign take = lane_a.valid && lane_b.valid;

  assign total = wide_t'(lane_a.sum) + wide_t'(lane_b.sum) + wide_t'(bias);

  ////////////////////
  // ReLU and saturation

  always_comb begin
    if (total < 0) begin
      act = '0;
    end else if (total > wide_t'(OUT_MAX)) begin
      act = OUT_MAX;
    end else begin
      act = out_t'(total);
    end
  end

  ////////////////////
  // Output register

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out  <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      valid_out  <= take;
      frame_done <= take && lane_a.last;
    end
  end

  // Lane B position is the same as lane A
  always_ff @(posedge clk) begin
    if (take) begin
      pxl_out   <= act;
      out_index <= lane_a.index;
    end
  end

endmodule

`default_nettype wire

// File: conv_channel_sum_top.sv
`timescale 1ns/1ns
`default_nettype none

module conv_channel_sum_top
  import conv_accum_pkg::*;
#(
  parameter int IMAGE_SIZE     = 16,
  parameter int CHANNEL_NUM_IN = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          valid_in,
  input  pxl_t                          pxl_a,
  input  pxl_t                          pxl_b,
  input  psum_t                         bias,
  output out_t                          pxl_out,
  output logic                          valid_out,
  output logic [$clog2(IMAGE_SIZE)-1:0] out_index,
  output logic                          frame_done
);

  psum_if #(.IMAGE_SIZE(IMAGE_SIZE)) psum_a_if ();
  psum_if #(.IMAGE_SIZE(IMAGE_SIZE)) psum_b_if ();

  ////////////////////
  // Lanes, even channels on A and odd on B

  channel_in_accum #(
    .IMAGE_SIZE     (IMAGE_SIZE),
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN)
  ) lane_a_i (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .pxl_in   (pxl_a),
    .out      (psum_a_if)
  );

  channel_in_accum #(
    .IMAGE_SIZE     (IMAGE_SIZE),
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN)
  ) lane_b_i (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .pxl_in   (pxl_b),
    .out      (psum_b_if)
  );

  ////////////////////
  // Bias, ReLU, saturation

  bias_relu_combiner #(
    .IMAGE_SIZE (IMAGE_SIZE)
  ) combiner_i (
    .clk        (clk),
    .reset      (reset),
    .lane_a     (psum_a_if),
    .lane_b     (psum_b_if),
    .bias       (bias),
    .pxl_out    (pxl_out),
    .valid_out  (valid_out),
    .out_index  (out_index),
    .frame_done (frame_done)
  );

endmodule

`default_nettype wire

// File: conv_sum_checker.sv
`timescale 1ns/1ns
`default_nettype none

module conv_sum_checker
  import conv_accum_pkg::*;
#(
  parameter int IMAGE_SIZE     = 16,
  parameter int CHANNEL_NUM_IN = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          valid_in,
  input  pxl_t                          pxl_a,
  input  pxl_t                          pxl_b,
  input  psum_t                         bias,
  input  out_t                          pxl_out,
  input  logic                          valid_out,
  input  logic [$clog2(IMAGE_SIZE)-1:0] out_index,
  input  logic                          frame_done,
  output int                            errors,
  output int                            checks,
  output int                            pending
);

  // Model sums per lane and pixel position
  longint sum_a [IMAGE_SIZE];
  longint sum_b [IMAGE_SIZE];
  int     pix = 0;
  int     ch = 0;
  int     outs_in_frame = 0;
  longint cycle = 0;
  int     err_cnt = 0;
  int     check_cnt = 0;
  int     pend_cnt = 0;

  // Expected outputs, oldest first
  longint exp_val_q [$];
  int     exp_idx_q [$];
  bit     exp_last_q [$];
  longint exp_due_q [$];

  assign errors  = err_cnt;
  assign checks  = check_cnt;
  assign pending = pend_cnt;

  task automatic compare(input string name, input longint expected, input longint actual);
    check_cnt++;
    if (expected != actual) begin
      err_cnt++;
      $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
    end
  endtask

  ////////////////////
  // Model of one sampled input

  task automatic model_input();
    longint total;
    if (ch == 0) begin
      sum_a[pix] = pxl_a;
      sum_b[pix] = pxl_b;
    end else begin
      sum_a[pix] += pxl_a;
      sum_b[pix] += pxl_b;
    end
    // Last channel publishes, ReLU then clamp
    if (ch == CHANNEL_NUM_IN - 1) begin
      total = sum_a[pix] + sum_b[pix] + longint'(bias);
      if (total < 0) begin
        total = 0;
      end else if (total > longint'(OUT_MAX)) begin
        total = longint'(OUT_MAX);
      end
      exp_val_q.push_back(total);
      exp_idx_q.push_back(pix);
      exp_last_q.push_back(pix == IMAGE_SIZE - 1);
      exp_due_q.push_back(cycle + 3);
    end
    if (pix == IMAGE_SIZE - 1) begin
      pix = 0;
      ch  = (ch == CHANNEL_NUM_IN - 1) ? 0 : ch + 1;
    end else begin
      pix++;
    end
  endtask

  task automatic check_output();
    if (exp_val_q.size() == 0) begin
      err_cnt++;
      $display("Output appeared at %0t while no result was expected", $time);
    end else begin
      compare("valid_out cycle", exp_due_q.pop_front(), cycle);
      compare("pxl_out", exp_val_q.pop_front(), pxl_out);
      compare("out_index", exp_idx_q.pop_front(), out_index);
      compare("frame_done", exp_last_q.pop_front(), frame_done);
      outs_in_frame++;
      if (frame_done) begin
        compare("outputs per frame", IMAGE_SIZE, outs_in_frame);
        outs_in_frame = 0;
      end
    end
  endtask

  ////////////////////
  // Sampling, once per rising edge

  always @(posedge clk) begin
    cycle++;
    if (reset) begin
      // In-flight results are dropped by the DUT too
      pix = 0;
      ch = 0;
      outs_in_frame = 0;
      exp_val_q.delete();
      exp_idx_q.delete();
      exp_last_q.delete();
      exp_due_q.delete();
    end else begin
      if (valid_out) begin
        check_output();
      end else if (frame_done) begin
        err_cnt++;
        $display("frame_done was high at %0t without valid_out", $time);
      end
      if (valid_in) begin
        model_input();
      end
    end
    pend_cnt = exp_val_q.size();
  end

endmodule

`default_nettype wire

// File: tb_conv_channel_sum.sv
`timescale 1ns/1ns
`default_nettype none

module tb_conv_channel_sum
  import conv_accum_pkg::*;
();

  localparam int IMAGE_SIZE     = 16;
  localparam int CHANNEL_NUM_IN = 4;
  localparam int FRAME_INPUTS   = IMAGE_SIZE * CHANNEL_NUM_IN;
  localparam int DONE_TIMEOUT   = 50;

  logic                          clk;
  logic                          reset;
  logic                          valid_in;
  pxl_t                          pxl_a;
  pxl_t                          pxl_b;
  psum_t                         bias;
  out_t                          pxl_out;
  logic                          valid_out;
  logic [$clog2(IMAGE_SIZE)-1:0] out_index;
  logic                          frame_done;
  int                            chk_errors;
  int                            chk_checks;
  int                            chk_pending;
  int                            tb_errors = 0;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  conv_channel_sum_top #(
    .IMAGE_SIZE     (IMAGE_SIZE),
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN)
  ) dut_i (
    .clk        (clk),
    .reset      (reset),
    .valid_in   (valid_in),
    .pxl_a      (pxl_a),
    .pxl_b      (pxl_b),
    .bias       (bias),
    .pxl_out    (pxl_out),
    .valid_out  (valid_out),
    .out_index  (out_index),
    .frame_done (frame_done)
  );

  conv_sum_checker #(
    .IMAGE_SIZE     (IMAGE_SIZE),
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN)
  ) chk_i (
    .clk        (clk),
    .reset      (reset),
    .valid_in   (valid_in),
    .pxl_a      (pxl_a),
    .pxl_b      (pxl_b),
    .bias       (bias),
    .pxl_out    (pxl_out),
    .valid_out  (valid_out),
    .out_index  (out_index),
    .frame_done (frame_done),
    .errors     (chk_errors),
    .checks     (chk_checks),
    .pending    (chk_pending)
  );

  function automatic pxl_t rand_pixel(input int lo, input int hi);
    return pxl_t'(lo + int'($urandom_range(hi - lo)));
  endfunction

  ////////////////////
  // Stimulus tasks

  // Sends count accepted inputs with valid on about 70 % of cycles
  task automatic drive_inputs(input int count, input int lo, input int hi);
    int sent;
    sent = 0;
    while (sent < count) begin
      @(posedge clk);
      if ($urandom_range(99) < 70) begin
        valid_in <= 1'b1;
        pxl_a    <= rand_pixel(lo, hi);
        pxl_b    <= rand_pixel(lo, hi);
        sent++;
      end else begin
        valid_in <= 1'b0;
      end
    end
    @(posedge clk);
    valid_in <= 1'b0;
  endtask

  task automatic wait_frame_done();
    int n;
    n = 0;
    while (!frame_done && n < DONE_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (!frame_done) begin
      tb_errors++;
      $display("Timeout: frame_done did not come within %0d cycles", DONE_TIMEOUT);
    end
  endtask

  // Bias only moves between frames
  task automatic run_frame(input psum_t frame_bias, input int lo, input int hi);
    bias <= frame_bias;
    drive_inputs(FRAME_INPUTS, lo, hi);
    wait_frame_done();
  endtask

  task automatic reset_mid_frame(input int count);
    drive_inputs(count, -100, 100);
    reset <= 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
  endtask

  ////////////////////
  // Main sequence

  initial begin
    void'($urandom(2422));
    reset    = 1'b1;
    valid_in = 1'b0;
    pxl_a    = '0;
    pxl_b    = '0;
    bias     = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // Small values without clamping
    run_frame(1500, -50, 200);
    run_frame(700, -50, 200);
    // ReLU
    run_frame(-200, -300, 300);
    run_frame(-100000, -32768, 32767);
    // Saturation and then both clamps mixed
    run_frame(0, 20000, 32767);
    run_frame(0, -32768, 32767);
    // Reset inside the last channel of a frame
    reset_mid_frame(FRAME_INPUTS - 8);
    run_frame(1200, -50, 200);
    run_frame(psum_t'($urandom_range(40000)) - 20000, -32768, 32767);

    repeat (5) @(posedge clk);
    @(negedge clk);
    if (chk_pending != 0) begin
      tb_errors++;
      $display("%0d expected outputs never appeared", chk_pending);
    end
    $display("errors %0d, checks %0d", chk_errors + tb_errors, chk_checks);
    if (chk_errors + tb_errors == 0 && chk_checks > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: conv_channel_sum_top.f
conv_accum_pkg.sv
psum_if.sv
psum_buffer.sv
channel_in_accum.sv
bias_relu_combiner.sv
conv_channel_sum_top.sv
conv_sum_checker.sv
tb_conv_channel_sum.sv
